// File: common/decoder_params.svh
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// Datapath widths
`define INSTR_W 32
`define STATE_W 10

// Instruction class field
`define CLASS_HI 27
`define CLASS_LO 25

// Single load/store addressing fields
`define P_BIT 24 // Pre/offset vs post-indexed
`define U_BIT 23 // Add offset when set
`define B_BIT 22 // Unsigned byte access
`define W_BIT 21 // Write back base
`define L_BIT 20 // Load when set

// Data processing and branch fields
`define S_BIT    20 // Set condition codes
`define LINK_BIT 24
`define OPC_HI   24
`define OPC_LO   21

// Bits that split misc load/store and register shifts out of the main classes
`define MISC_BIT7      7
`define REG_SHIFT_BIT4 4

`endif

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Instruction groups seen by the state encoder
    typedef enum logic [2:0] {
        CLS_LDST_IMM,
        CLS_LDST_REG,
        CLS_DP_CMP,      // Flag-only compares, no result write
        CLS_DP,
        CLS_BRANCH,
        CLS_UNSUPPORTED  // Falls back to fetch
    } instr_class_e;

    typedef enum logic [3:0] {
        OPC_AND = 4'b0000,
        OPC_EOR = 4'b0001,
        OPC_SUB = 4'b0010,
        OPC_RSB = 4'b0011,
        OPC_ADD = 4'b0100,
        OPC_ADC = 4'b0101,
        OPC_SBC = 4'b0110,
        OPC_RSC = 4'b0111,
        OPC_TST = 4'b1000,
        OPC_TEQ = 4'b1001,
        OPC_CMP = 4'b1010,
        OPC_CMN = 4'b1011,
        OPC_ORR = 4'b1100,
        OPC_MOV = 4'b1101,
        OPC_BIC = 4'b1110,
        OPC_MVN = 4'b1111
    } dp_opcode_e;

endpackage

`default_nettype wire

// File: common/ctrl_pkg.sv
`default_nettype none

`include "decoder_params.svh"

package ctrl_pkg;

    // Microsequencer entry points, store/load pairs side by side
    typedef enum logic [`STATE_W-1:0] {
        ST_FETCH  = 10'd1,
        ST_DP_S   = 10'd10,
        ST_DP     = 10'd11,
        ST_B      = 10'd12,
        ST_BL     = 10'd13,
        ST_DP_CMP = 10'd14,

        // Immediate offset
        ST_STRB_IMM_OFS_ADD  = 10'd20, ST_LDRB_IMM_OFS_ADD  = 10'd66,
        ST_STRB_IMM_OFS_SUB  = 10'd30, ST_LDRB_IMM_OFS_SUB  = 10'd74,
        ST_STR_IMM_OFS_ADD   = 10'd43, ST_LDR_IMM_OFS_ADD   = 10'd85,
        ST_STR_IMM_OFS_SUB   = 10'd53, ST_LDR_IMM_OFS_SUB   = 10'd93,
        ST_STRB_IMM_PRE_ADD  = 10'd22, ST_LDRB_IMM_PRE_ADD  = 10'd68,
        ST_STRB_IMM_PRE_SUB  = 10'd32, ST_LDRB_IMM_PRE_SUB  = 10'd76,
        ST_STR_IMM_PRE_ADD   = 10'd45, ST_LDR_IMM_PRE_ADD   = 10'd87,
        ST_STR_IMM_PRE_SUB   = 10'd55, ST_LDR_IMM_PRE_SUB   = 10'd95,
        ST_STRB_IMM_POST_ADD = 10'd24, ST_LDRB_IMM_POST_ADD = 10'd70,
        ST_STRB_IMM_POST_SUB = 10'd34, ST_LDRB_IMM_POST_SUB = 10'd78,
        ST_STR_IMM_POST_ADD  = 10'd47, ST_LDR_IMM_POST_ADD  = 10'd89,
        ST_STR_IMM_POST_SUB  = 10'd57, ST_LDR_IMM_POST_SUB  = 10'd97,

        // Register offset
        ST_STRB_REG_OFS_ADD  = 10'd21, ST_LDRB_REG_OFS_ADD  = 10'd67,
        ST_STRB_REG_OFS_SUB  = 10'd31, ST_LDRB_REG_OFS_SUB  = 10'd75,
        ST_STR_REG_OFS_ADD   = 10'd44, ST_LDR_REG_OFS_ADD   = 10'd86,
        ST_STR_REG_OFS_SUB   = 10'd54, ST_LDR_REG_OFS_SUB   = 10'd94,
        ST_STRB_REG_PRE_ADD  = 10'd23, ST_LDRB_REG_PRE_ADD  = 10'd69,
        ST_STRB_REG_PRE_SUB  = 10'd33, ST_LDRB_REG_PRE_SUB  = 10'd77,
        ST_STR_REG_PRE_ADD   = 10'd46, ST_LDR_REG_PRE_ADD   = 10'd88,
        ST_STR_REG_PRE_SUB   = 10'd56, ST_LDR_REG_PRE_SUB   = 10'd96,
        ST_STRB_REG_POST_ADD = 10'd27, ST_LDRB_REG_POST_ADD = 10'd72,
        ST_STRB_REG_POST_SUB = 10'd37, ST_LDRB_REG_POST_SUB = 10'd80,
        ST_STR_REG_POST_ADD  = 10'd50, ST_LDR_REG_POST_ADD  = 10'd91,
        ST_STR_REG_POST_SUB  = 10'd60, ST_LDR_REG_POST_SUB  = 10'd99
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: source/instr_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_params.svh"

module instr_classifier (
    input  wire [`INSTR_W-1:0]    instruction,
    output isa_pkg::instr_class_e instr_class
);

    import isa_pkg::*;

    logic [2:0] class_bits;
    dp_opcode_e opcode;
    logic       is_dp_enc;
    logic       is_cmp_op;
    logic       is_misc_ldst;

    assign class_bits = instruction[`CLASS_HI:`CLASS_LO];
    assign opcode     = dp_opcode_e'(instruction[`OPC_HI:`OPC_LO]);

    // Immediate or register operand 2
    assign is_dp_enc = (class_bits == 3'b000) || (class_bits == 3'b001);

    // TST/TEQ/CMP/CMN only update flags
    assign is_cmp_op = (opcode == OPC_TST) || (opcode == OPC_TEQ) ||
                       (opcode == OPC_CMP) || (opcode == OPC_CMN);

    // Halfword, signed byte and doubleword transfers
    assign is_misc_ldst = (class_bits == 3'b000) &&
                          instruction[`MISC_BIT7] && instruction[`REG_SHIFT_BIT4];

    // First match wins
    always_comb
    begin
        if (class_bits == 3'b010)
        begin
            instr_class = CLS_LDST_IMM;
        end
        else if (class_bits == 3'b011 && !instruction[`REG_SHIFT_BIT4])
        begin
            instr_class = CLS_LDST_REG; // Bit 4 set is a media op here
        end
        else if (is_misc_ldst)
        begin
            instr_class = CLS_UNSUPPORTED;
        end
        else if (is_dp_enc && is_cmp_op)
        begin
            instr_class = CLS_DP_CMP;
        end
        else if (is_dp_enc)
        begin
            instr_class = CLS_DP;
        end
        else if (class_bits == 3'b101)
        begin
            instr_class = CLS_BRANCH;
        end
        else
        begin
            instr_class = CLS_UNSUPPORTED; // Includes LDM/STM (100)
        end
    end

endmodule

`default_nettype wire

// File: ldst/ldst_state_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_params.svh"

module ldst_state_encoder (
    input  wire [`INSTR_W-1:0]   instruction,
    output ctrl_pkg::ctrl_state_e ldst_state
);

    import ctrl_pkg::*;

    logic       reg_offset;
    logic [1:0] addr_mode; // 00 offset, 01 pre-indexed, 10 post-indexed
    logic [5:0] sel;

    assign reg_offset = instruction[`CLASS_LO];

    always_comb
    begin
        if (!instruction[`P_BIT])
        begin
            addr_mode = 2'b10; // Post-indexed, W has no effect
        end
        else if (instruction[`W_BIT])
        begin
            addr_mode = 2'b01;
        end
        else
        begin
            addr_mode = 2'b00;
        end
    end

    // {reg_offset, mode, byte, add, load}
    assign sel = {reg_offset, addr_mode, instruction[`B_BIT],
                  instruction[`U_BIT], instruction[`L_BIT]};

    always_comb
    begin
        case (sel)
            // Immediate offset
            6'b0_00_1_1_0: ldst_state = ST_STRB_IMM_OFS_ADD;
            6'b0_00_1_1_1: ldst_state = ST_LDRB_IMM_OFS_ADD;
            6'b0_00_1_0_0: ldst_state = ST_STRB_IMM_OFS_SUB;
            6'b0_00_1_0_1: ldst_state = ST_LDRB_IMM_OFS_SUB;
            6'b0_00_0_1_0: ldst_state = ST_STR_IMM_OFS_ADD;
            6'b0_00_0_1_1: ldst_state = ST_LDR_IMM_OFS_ADD;
            6'b0_00_0_0_0: ldst_state = ST_STR_IMM_OFS_SUB;
            6'b0_00_0_0_1: ldst_state = ST_LDR_IMM_OFS_SUB;
            6'b0_01_1_1_0: ldst_state = ST_STRB_IMM_PRE_ADD;
            6'b0_01_1_1_1: ldst_state = ST_LDRB_IMM_PRE_ADD;
            6'b0_01_1_0_0: ldst_state = ST_STRB_IMM_PRE_SUB;
            6'b0_01_1_0_1: ldst_state = ST_LDRB_IMM_PRE_SUB;
            6'b0_01_0_1_0: ldst_state = ST_STR_IMM_PRE_ADD;
            6'b0_01_0_1_1: ldst_state = ST_LDR_IMM_PRE_ADD;
            6'b0_01_0_0_0: ldst_state = ST_STR_IMM_PRE_SUB;
            6'b0_01_0_0_1: ldst_state = ST_LDR_IMM_PRE_SUB;
            6'b0_10_1_1_0: ldst_state = ST_STRB_IMM_POST_ADD;
            6'b0_10_1_1_1: ldst_state = ST_LDRB_IMM_POST_ADD;
            6'b0_10_1_0_0: ldst_state = ST_STRB_IMM_POST_SUB;
            6'b0_10_1_0_1: ldst_state = ST_LDRB_IMM_POST_SUB;
            6'b0_10_0_1_0: ldst_state = ST_STR_IMM_POST_ADD;
            6'b0_10_0_1_1: ldst_state = ST_LDR_IMM_POST_ADD;
            6'b0_10_0_0_0: ldst_state = ST_STR_IMM_POST_SUB;
            6'b0_10_0_0_1: ldst_state = ST_LDR_IMM_POST_SUB;
            // Register offset
            6'b1_00_1_1_0: ldst_state = ST_STRB_REG_OFS_ADD;
            6'b1_00_1_1_1: ldst_state = ST_LDRB_REG_OFS_ADD;
            6'b1_00_1_0_0: ldst_state = ST_STRB_REG_OFS_SUB;
            6'b1_00_1_0_1: ldst_state = ST_LDRB_REG_OFS_SUB;
            6'b1_00_0_1_0: ldst_state = ST_STR_REG_OFS_ADD;
            6'b1_00_0_1_1: ldst_state = ST_LDR_REG_OFS_ADD;
            6'b1_00_0_0_0: ldst_state = ST_STR_REG_OFS_SUB;
            6'b1_00_0_0_1: ldst_state = ST_LDR_REG_OFS_SUB;
            6'b1_01_1_1_0: ldst_state = ST_STRB_REG_PRE_ADD;
            6'b1_01_1_1_1: ldst_state = ST_LDRB_REG_PRE_ADD;
            6'b1_01_1_0_0: ldst_state = ST_STRB_REG_PRE_SUB;
            6'b1_01_1_0_1: ldst_state = ST_LDRB_REG_PRE_SUB; // 77
            6'b1_01_0_1_0: ldst_state = ST_STR_REG_PRE_ADD;
            6'b1_01_0_1_1: ldst_state = ST_LDR_REG_PRE_ADD;
            6'b1_01_0_0_0: ldst_state = ST_STR_REG_PRE_SUB;
            6'b1_01_0_0_1: ldst_state = ST_LDR_REG_PRE_SUB;
            6'b1_10_1_1_0: ldst_state = ST_STRB_REG_POST_ADD;
            6'b1_10_1_1_1: ldst_state = ST_LDRB_REG_POST_ADD;
            6'b1_10_1_0_0: ldst_state = ST_STRB_REG_POST_SUB;
            6'b1_10_1_0_1: ldst_state = ST_LDRB_REG_POST_SUB;
            6'b1_10_0_1_0: ldst_state = ST_STR_REG_POST_ADD;
            6'b1_10_0_1_1: ldst_state = ST_LDR_REG_POST_ADD;
            6'b1_10_0_0_0: ldst_state = ST_STR_REG_POST_SUB;
            6'b1_10_0_0_1: ldst_state = ST_LDR_REG_POST_SUB;
            default:       ldst_state = ST_FETCH; // Mode 11 never occurs
        endcase
    end

endmodule

`default_nettype wire

// File: source/next_state_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_params.svh"

module next_state_reg (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      decode_en,
    input  wire [`INSTR_W-1:0]       instruction,
    input  var isa_pkg::instr_class_e instr_class,
    input  var ctrl_pkg::ctrl_state_e ldst_state,
    output ctrl_pkg::ctrl_state_e     state_number
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    ctrl_state_e next_state;

    always_comb
    begin
        case (instr_class)
            CLS_LDST_IMM,
            CLS_LDST_REG:
            begin
                next_state = ldst_state;
            end
            CLS_DP_CMP:
            begin
                next_state = ST_DP_CMP; // S is implied for compares
            end
            CLS_DP:
            begin
                next_state = instruction[`S_BIT] ? ST_DP_S : ST_DP;
            end
            CLS_BRANCH:
            begin
                next_state = instruction[`LINK_BIT] ? ST_BL : ST_B;
            end
            default:
            begin
                next_state = ST_FETCH; // Unknown encodings refetch
            end
        endcase
    end

    // Holds the last decode while decode_en is low
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_number <= ST_FETCH;
        end
        else if (decode_en)
        begin
            state_number <= next_state;
        end
    end

endmodule

`default_nettype wire

// File: source/instr_state_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_params.svh"

module instr_state_encoder (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [`INSTR_W-1:0]    instruction,
    input  wire                   decode_en,
    output ctrl_pkg::ctrl_state_e state_number
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    instr_class_e instr_class;
    ctrl_state_e  ldst_state;

    instr_classifier u_classifier (
        .instruction (instruction),
        .instr_class (instr_class)
    );

    // Bit 25 picks immediate vs register offset inside
    ldst_state_encoder u_ldst_enc (
        .instruction (instruction),
        .ldst_state  (ldst_state)
    );

    next_state_reg u_state_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .decode_en    (decode_en),
        .instruction  (instruction),
        .instr_class  (instr_class),
        .ldst_state   (ldst_state),
        .state_number (state_number)
    );

endmodule

`default_nettype wire

// File: dv/instr_state_encoder_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module instr_state_encoder_assertions (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       decode_en,
    input  var ctrl_pkg::ctrl_state_e state_number
);

    import ctrl_pkg::*;

    // Async reset forces the fetch state
    assert property (@(posedge clk) !rst_n |-> state_number == ST_FETCH)
        else $error("state_number left ST_FETCH during reset");

    assert property (@(posedge clk) disable iff (!rst_n)
                     !decode_en |=> $stable(state_number))
        else $error("state_number changed while decode_en was low");

    assert property (@(posedge clk) !$isunknown(state_number))
        else $error("state_number has unknown bits"); // X or Z on output

endmodule

bind instr_state_encoder instr_state_encoder_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .decode_en    (decode_en),
    .state_number (state_number)
);

`default_nettype wire

// File: dv/tb_instr_state_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_params.svh"

module tb_instr_state_encoder;

    import ctrl_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int MARGIN_CYCLES = 20;

    // Store/load state numbers per addressing row, offset then pre then post
    localparam logic [`STATE_W-1:0] IMM_ST [12] = '{10'd20, 10'd30, 10'd43, 10'd53,
        10'd22, 10'd32, 10'd45, 10'd55, 10'd24, 10'd34, 10'd47, 10'd57};
    localparam logic [`STATE_W-1:0] IMM_LD [12] = '{10'd66, 10'd74, 10'd85, 10'd93,
        10'd68, 10'd76, 10'd87, 10'd95, 10'd70, 10'd78, 10'd89, 10'd97};
    localparam logic [`STATE_W-1:0] REG_ST [12] = '{10'd21, 10'd31, 10'd44, 10'd54,
        10'd23, 10'd33, 10'd46, 10'd56, 10'd27, 10'd37, 10'd50, 10'd60};
    localparam logic [`STATE_W-1:0] REG_LD [12] = '{10'd67, 10'd75, 10'd86, 10'd94,
        10'd69, 10'd77, 10'd88, 10'd96, 10'd72, 10'd80, 10'd91, 10'd99};

    logic                clk = 1'b0;
    logic                rst_n = 1'b1;
    logic [`INSTR_W-1:0] instruction;
    logic                decode_en;
    ctrl_state_e         state_number;

    // Stimulus table
    logic [31:0] fixed_q [$];
    logic [31:0] mask_q [$];   // Set bits are filled from the LFSR
    logic        en_q [$];
    ctrl_state_e exp_q [$];
    string       name_q [$];

    logic [31:0] lfsr = 32'h8003_3679;
    int          num_entries = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    instr_state_encoder UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instruction  (instruction),
        .decode_en    (decode_en),
        .state_number (state_number)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    task automatic fill_free_bits(input logic [31:0] fixed, input logic [31:0] mask,
                                  output logic [31:0] word);
        int b;
        for (b = 0; b < 32; b++)
        begin
            if (mask[b])
            begin
                lfsr = lfsr_next(lfsr); // One step per random bit
                word[b] = lfsr[0];
            end
            else
            begin
                word[b] = fixed[b];
            end
        end
    endtask

    task automatic add_entry(input logic [31:0] fixed, input logic [31:0] mask,
                             input logic en, input ctrl_state_e exp, input string name);
        fixed_q.push_back(fixed);
        mask_q.push_back(mask);
        en_q.push_back(en);
        exp_q.push_back(exp);
        name_q.push_back(name);
    endtask

    // Disabled decode keeps whatever the previous entry produced
    task automatic add_hold(input logic [31:0] fixed, input logic [31:0] mask);
        add_entry(fixed, mask, 1'b0, exp_q[exp_q.size() - 1], "hold");
    endtask

    task automatic build_table();
        int          rg;
        int          mode;
        int          sz;
        int          add;
        int          ld;
        int          row;
        int          opc;
        int          s;
        logic [31:0] word;
        logic [31:0] mask;
        logic [`STATE_W-1:0] code;
        add_entry(32'h0B00_0000, 32'hF0FF_FFFF, 1'b0, ST_FETCH, "hold");
        for (rg = 0; rg < 2; rg++)
            for (mode = 0; mode < 3; mode++)
                for (sz = 0; sz < 2; sz++)
                    for (add = 0; add < 2; add++)
                        for (ld = 0; ld < 2; ld++)
                        begin
                            word = '0;
                            word[`CLASS_HI:`CLASS_LO] = (rg != 0) ? 3'b011 : 3'b010;
                            word[`P_BIT] = (mode != 2);
                            word[`W_BIT] = (mode == 1);
                            word[`B_BIT] = sz[0];
                            word[`U_BIT] = add[0];
                            word[`L_BIT] = ld[0];
                            mask = 32'hF00F_FFFF;
                            if (rg != 0)
                                mask[`REG_SHIFT_BIT4] = 1'b0; // Bit 4 set is not a load/store
                            if (mode == 2)
                                mask[`W_BIT] = 1'b1;          // Post-indexed ignores W
                            row = mode * 4 + ((sz != 0) ? 0 : 2) + ((add != 0) ? 0 : 1);
                            if (rg != 0)
                                code = (ld != 0) ? REG_LD[row] : REG_ST[row];
                            else
                                code = (ld != 0) ? IMM_LD[row] : IMM_ST[row];
                            add_entry(word, mask, 1'b1, ctrl_state_e'(code),
                                      (rg != 0) ? "ldst_reg" : "ldst_imm");
                        end
        add_hold(32'h0B00_0000, 32'hF0FF_FFFF);
        for (rg = 0; rg < 2; rg++)
            for (opc = 0; opc < 16; opc++)
                for (s = 0; s < 2; s++)
                begin
                    word = '0;
                    word[`CLASS_LO] = rg[0];
                    word[`OPC_HI:`OPC_LO] = opc[3:0];
                    word[`S_BIT] = s[0];
                    // Bit 4 clear keeps class 000 away from misc load/store
                    mask = (rg != 0) ? 32'hF00F_FFFF : 32'hF00F_FFEF;
                    if (opc >= 8 && opc <= 11)
                        add_entry(word, mask, 1'b1, ST_DP_CMP, "dp_cmp");
                    else
                        add_entry(word, mask, 1'b1, (s != 0) ? ST_DP_S : ST_DP, "dp");
                end
        add_hold(32'h0590_0000, 32'hF00F_FFFF);
        add_entry(32'h0A00_0000, 32'hF0FF_FFFF, 1'b1, ST_B, "branch");
        add_entry(32'h0B00_0000, 32'hF0FF_FFFF, 1'b1, ST_BL, "branch");
        add_entry(32'h0A00_0000, 32'hF0FF_FFFF, 1'b1, ST_B, "branch");
        add_entry(32'h0B00_0000, 32'hF0FF_FFFF, 1'b1, ST_BL, "branch");
        add_hold(32'h01A0_0000, 32'hF00F_FFEF);
        add_entry(32'h0000_0090, 32'hF1FF_FF6F, 1'b1, ST_FETCH, "unsupported"); // Misc ld/st
        add_entry(32'h0600_0010, 32'hF1FF_FFEF, 1'b1, ST_FETCH, "unsupported");
        add_entry(32'h0800_0000, 32'hF1FF_FFFF, 1'b1, ST_FETCH, "unsupported"); // LDM/STM
        add_entry(32'h0C00_0000, 32'hF1FF_FFFF, 1'b1, ST_FETCH, "unsupported");
        add_entry(32'h0E00_0000, 32'hF1FF_FFFF, 1'b1, ST_FETCH, "unsupported");
        num_entries = fixed_q.size();
    endtask

    task automatic check_entry(input int idx, input logic [31:0] applied);
        if (state_number !== exp_q[idx])
        begin
            $display("** Error at %0d ns: state_number = %0d, expected %0d",
                     $time, state_number, exp_q[idx]);
            $display("%-11s #%0d instr=%h state_number=%0d MISMATCH",
                     name_q[idx], idx, applied, state_number);
            fail_count++;
        end
        else
        begin
            $display("%-11s #%0d instr=%h state_number=%0d ok",
                     name_q[idx], idx, applied, state_number);
            pass_count++;
        end
    endtask

    initial
    begin
        logic [31:0] word;
        logic [31:0] applied;
        int          i;
        instruction = '0;
        decode_en   = 1'b0;
        rst_n       <= 1'b0;
        word        = '0;
        applied     = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (state_number !== ST_FETCH)
        begin
            $display("** Error at %0d ns: state_number = %0d, expected %0d",
                     $time, state_number, ST_FETCH);
            fail_count++;
        end
        else
        begin
            $display("reset       state_number=%0d ok", state_number);
            pass_count++;
        end
        // Entry i is driven while entry i-1 is checked
        for (i = 0; i <= num_entries; i++)
        begin
            @(posedge clk);
            if (i < num_entries)
            begin
                fill_free_bits(fixed_q[i], mask_q[i], word);
                instruction <= word;
                decode_en   <= en_q[i];
            end
            else
            begin
                decode_en <= 1'b0;
            end
            @(negedge clk);
            if (i > 0)
                check_entry(i - 1, applied);
            applied = word;
        end
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        wait (num_entries > 0);
        #((num_entries + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all table entries were checked");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: instr_state_encoder.f
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
source/instr_classifier.sv
ldst/ldst_state_encoder.sv
source/next_state_reg.sv
source/instr_state_encoder.sv
dv/instr_state_encoder_assertions.sv
dv/tb_instr_state_encoder.sv

// File: Makefile
TOP      = tb_instr_state_encoder
FILELIST = instr_state_encoder.f

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f $(FILELIST) --top-module $(TOP)

# Pass only when the simulation prints the pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
